// File: flist.f
+incdir+common
common/ufiPkg.sv
common/ufiSlaveIf.sv
ufiArbiter/ufiArbiter.sv
verilog/ufiBlockRam.sv
verilog/ufiMemSubsystem.sv
tb/ufiClockGen.sv
tb/ufiMemSubsystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it, check the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir \
	&& verilator --binary --timing --assert -f flist.f \
		--top-module ufiMemSubsystemTb -o simv \
	&& ./obj_dir/simv 2>&1 | tee "$LOG" \
	|| { echo "Build or simulation run failed"; exit 1; }

grep -q "SOME TESTS FAILED" "$LOG" \
	&& { echo "Simulation reported errors, see $LOG"; exit 1; } \
	|| { echo "Simulation clean"; exit 0; }

// File: tb/ufiMemSubsystemTb.sv
/* Testbench for the memory bus subsystem
   Cycle table with grant and memory model, then random VTB traffic */
`timescale 1ns/1ps

`include "ufi_settings.svh"

module ufiMemSubsystemTb;

	// Master select masks, MCS SPI ATB VTB from the top bit down
	localparam logic [3:0] selNone = 4'b0000;
	localparam logic [3:0] selMcs = 4'b1000;
	localparam logic [3:0] selSpi = 4'b0100;
	localparam logic [3:0] selAtb = 4'b0010;
	localparam logic [3:0] selVtb = 4'b0001;
	localparam bit cmdRd = ufiPkg::UFI_CMD_READ;
	localparam bit cmdWr = ufiPkg::UFI_CMD_WRITE;

	// One table row is one clock of stimulus
	typedef struct packed
	{
		logic [3:0] vd;		// Active masters
		logic ed;		// Enable for all active masters
		logic cmd;		// SPI and VTB command, ATB ignores it
		ufiPkg::ufiAdrsT adrs;		// VTB uses the next word
		ufiPkg::ufiDataT wd;
		ufiPkg::ufiGrantT expGrant;		// Winner by the priority rule
	} rowT;

	bit iUfiClk;
	bit rstN;
	ufiPkg::ufiDataT mcsWd, spiWd, vtbWd;
	ufiPkg::ufiAdrsT mcsAdrs, spiAdrs, atbAdrs, vtbAdrs;
	bit mcsEd, spiEd, atbEd, vtbEd;
	bit mcsVd, spiVd, atbVd, vtbVd;
	bit spiCmd, vtbCmd;
	bit atbRdy, vtbRdy;
	ufiPkg::ufiDataT masterRd;
	bit masterRed;

	rowT stimRows[$];
	ufiPkg::ufiDataT refMem [2**`UFI_RAM_ADRS_BITS];		// Reference memory
	bit mAtbRdy, mVtbRdy;		// Model ready flags
	bit pipeRed [1:3];		// Expected read return, 3 stages
	ufiPkg::ufiDataT pipeRd [1:3];
	logic [31:0] rngState = 32'd63890;
	int errCount = 0;

	ufiClockGen clockGen (.iUfiClk(iUfiClk), .rstN(rstN));

	ufiMemSubsystem UUT (.*);

	// ---------------------------------------------------------------------------
	// Models and checks
	// ---------------------------------------------------------------------------
	function automatic logic [31:0] xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Fixed priority, ATB and VTB each locked out right after the other
	function automatic ufiPkg::ufiGrantT pickGrant(input logic [3:0] vd, input bit aRdy,
		input bit vRdy);
		if (vd[3])
			return ufiPkg::GRANT_MCS;
		if (vd[2])
			return ufiPkg::GRANT_SPI;
		if (vd[1] && !vRdy)
			return ufiPkg::GRANT_ATB;
		if (vd[0] && !aRdy)
			return ufiPkg::GRANT_VTB;
		return ufiPkg::GRANT_NONE;
	endfunction

	task automatic checkData(input string name, input ufiPkg::ufiDataT got,
		input ufiPkg::ufiDataT exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic checkBit(input string name, input bit got, input bit exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errCount++;
		end
	endtask

	task automatic addRow(input logic [3:0] vd, input bit ed, input bit cmd,
		input ufiPkg::ufiAdrsT adrs, input ufiPkg::ufiDataT wd, input ufiPkg::ufiGrantT g);
		rowT r;
		r.vd = vd;
		r.ed = ed;
		r.cmd = cmd;
		r.adrs = adrs;
		r.wd = wd;
		r.expGrant = g;
		stimRows.push_back(r);
	endtask

	// Same data and address to every active master
	task automatic driveRequest(input logic [3:0] vd, input bit ed, input bit cmd,
		input ufiPkg::ufiAdrsT adrs, input ufiPkg::ufiDataT wd);
		{mcsVd, spiVd, atbVd, vtbVd} = vd;
		{mcsEd, spiEd, atbEd, vtbEd} = vd & {4{ed}};
		{mcsWd, spiWd, vtbWd} = {3{wd}};
		{mcsAdrs, spiAdrs, atbAdrs} = {3{adrs}};
		vtbAdrs = adrs + 32'd1;
		spiCmd = cmd;
		vtbCmd = cmd;
	endtask

	// Ready from the last row, read return from three rows back
	task automatic checkOutputs();
		checkBit("atbRdy", atbRdy, mAtbRdy);
		checkBit("vtbRdy", vtbRdy, mVtbRdy);
		checkBit("masterRed", masterRed, pipeRed[3]);
		if (pipeRed[3])
			checkData("masterRd", masterRd, pipeRd[3]);
	endtask

	task automatic modelRow(input int idx, input rowT row);
		ufiPkg::ufiGrantT g;
		ufiPkg::ufiAdrsT a;
		bit en;
		bit isRead;
		g = pickGrant(row.vd, mAtbRdy, mVtbRdy);
		if (g != row.expGrant)
		begin
			$display("Table row %0d expects grant %s but the rule gives %s", idx,
				row.expGrant.name(), g.name());
			errCount++;
		end
		en = (g != ufiPkg::GRANT_NONE) && row.ed;
		isRead = (g == ufiPkg::GRANT_ATB) || (row.cmd == cmdRd &&
			(g == ufiPkg::GRANT_SPI || g == ufiPkg::GRANT_VTB));		// MCS never reads
		a = (g == ufiPkg::GRANT_VTB) ? row.adrs + 32'd1 : row.adrs;
		pipeRed[3] = pipeRed[2];
		pipeRd[3] = pipeRd[2];
		pipeRed[2] = pipeRed[1];
		pipeRd[2] = pipeRd[1];
		pipeRed[1] = en && isRead;
		pipeRd[1] = refMem[a[`UFI_RAM_ADRS_BITS-1:0]];		// Old contents
		if (en && !isRead)
			refMem[a[`UFI_RAM_ADRS_BITS-1:0]] = row.wd;
		mAtbRdy = (g == ufiPkg::GRANT_ATB);
		mVtbRdy = (g == ufiPkg::GRANT_VTB);
	endtask

	task automatic waitVtbReady(output bit seen);
		seen = 1'b0;
		for (int n = 0; n < 8 && !seen; n++)
		begin
			@(negedge iUfiClk);
			seen = vtbRdy;
		end
	endtask

	task automatic waitReadValid(output bit seen);
		seen = 1'b0;
		for (int n = 0; n < 8 && !seen; n++)
		begin
			@(negedge iUfiClk);
			seen = masterRed;
		end
	endtask

	// ---------------------------------------------------------------------------
	// Stimulus table
	// ---------------------------------------------------------------------------
	task automatic buildTable();
		addRow(selNone, 1'b0, cmdRd, 32'h0, 16'h0, ufiPkg::GRANT_NONE);
		addRow(selMcs, 1'b1, cmdWr, 32'h010, 16'hA5A5, ufiPkg::GRANT_MCS);
		addRow(selNone, 1'b0, cmdRd, 32'h0, 16'h0, ufiPkg::GRANT_NONE);
		addRow(selSpi, 1'b1, cmdRd, 32'h010, 16'h0, ufiPkg::GRANT_SPI);		// Readback
		addRow(selMcs, 1'b0, cmdWr, 32'h010, 16'hFFFF, ufiPkg::GRANT_MCS);		// Enable low
		addRow(selSpi, 1'b1, cmdRd, 32'h010, 16'h0, ufiPkg::GRANT_SPI);
		addRow(selMcs | selSpi, 1'b1, cmdRd, 32'h020, 16'h1234, ufiPkg::GRANT_MCS);
		addRow(selSpi, 1'b1, cmdRd, 32'h020, 16'h0, ufiPkg::GRANT_SPI);
		addRow(selMcs, 1'b1, cmdWr, 32'h030, 16'hBEEF, ufiPkg::GRANT_MCS);
		addRow(selMcs, 1'b1, cmdWr, 32'h031, 16'hCAFE, ufiPkg::GRANT_MCS);
		addRow(selAtb, 1'b1, cmdWr, 32'h030, 16'h0, ufiPkg::GRANT_ATB);		// Still a read
		addRow(selNone, 1'b0, cmdRd, 32'h0, 16'h0, ufiPkg::GRANT_NONE);
		addRow(selAtb | selVtb, 1'b1, cmdRd, 32'h030, 16'h0, ufiPkg::GRANT_ATB);
		addRow(selVtb, 1'b1, cmdRd, 32'h030, 16'h0, ufiPkg::GRANT_NONE);		// VTB waits
		addRow(selVtb, 1'b1, cmdRd, 32'h030, 16'h0, ufiPkg::GRANT_VTB);
		addRow(selAtb, 1'b1, cmdRd, 32'h010, 16'h0, ufiPkg::GRANT_NONE);		// ATB waits
		addRow(selAtb, 1'b1, cmdRd, 32'h010, 16'h0, ufiPkg::GRANT_ATB);
		repeat (3) addRow(selNone, 1'b0, cmdRd, 32'h0, 16'h0, ufiPkg::GRANT_NONE);
	endtask

	// ---------------------------------------------------------------------------
	// Run
	// ---------------------------------------------------------------------------
	initial
	begin
		logic [31:0] r;
		logic [3:0] slot;
		ufiPkg::ufiAdrsT adrs;
		ufiPkg::ufiAdrsT vAdrs;
		ufiPkg::ufiDataT data;
		bit doRead;
		bit seen;
		bit known [16];
		driveRequest(selNone, 1'b0, cmdRd, 32'h0, 16'h0);
		buildTable();
		seen = 1'b0;
		for (int n = 0; n < 40 && !seen; n++)
		begin
			@(negedge iUfiClk);
			seen = rstN;
		end
		if (!seen)
		begin
			$display("Reset was never released");
			errCount++;
		end
		else
		begin
			// Idle bus right after reset
			checkBit("masterRed", masterRed, 1'b0);
			checkBit("atbRdy", atbRdy, 1'b0);
			checkBit("vtbRdy", vtbRdy, 1'b0);
			foreach (stimRows[i])
			begin
				checkOutputs();
				driveRequest(stimRows[i].vd, stimRows[i].ed, stimRows[i].cmd,
					stimRows[i].adrs, stimRows[i].wd);
				modelRow(i, stimRows[i]);
				@(negedge iUfiClk);
			end
			checkOutputs();

			// Random VTB traffic on 16 words, reads only where written
			for (int k = 0; k < 40 && seen; k++)
			begin
				r = xorshift();
				slot = r[3:0];
				doRead = r[8] && known[slot];
				data = r[31:16];
				adrs = (xorshift() & 32'hFFFF_F000) | (32'h100 + {28'd0, slot});
				vAdrs = adrs + 32'd1;
				driveRequest(selVtb, 1'b1, doRead ? cmdRd : cmdWr, adrs, data);
				waitVtbReady(seen);
				driveRequest(selNone, 1'b0, cmdRd, 32'h0, 16'h0);
				if (!seen)
				begin
					$display("Timeout: VTB request %0d was never granted", k);
					errCount++;
				end
				else if (doRead)
				begin
					waitReadValid(seen);
					if (!seen)
					begin
						$display("Timeout: no read data for VTB request %0d", k);
						errCount++;
					end
					else
						checkData("masterRd", masterRd, refMem[vAdrs[`UFI_RAM_ADRS_BITS-1:0]]);
				end
				else
				begin
					refMem[vAdrs[`UFI_RAM_ADRS_BITS-1:0]] = data;
					known[slot] = 1'b1;
				end
			end
		end
		$display("Errors: %0d", errCount);
		if (errCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: tb/ufiClockGen.sv
/* Testbench clock and synchronous reset source
   40 ns clock, reset held low for 16 cycles */
`timescale 1ns/1ps

module ufiClockGen
(
	output bit iUfiClk,
	output bit rstN
);

	initial
	begin
		iUfiClk = 1'b0;
		forever #20 iUfiClk = ~iUfiClk;		// 40 ns period
	end

	initial
	begin
		rstN = 1'b0;
		repeat (16) @(posedge iUfiClk);
		@(negedge iUfiClk);
		rstN = 1'b1;		// Release away from the sampling edge
	end

endmodule

// File: verilog/ufiMemSubsystem.sv
/* Memory bus subsystem top level
   Arbiter and block RAM joined by the slave bus interface */
`timescale 1ns/1ps

module ufiMemSubsystem
(
	input bit iUfiClk,
	input bit rstN,
	// MCS, write only
	input ufiPkg::ufiDataT mcsWd,
	input ufiPkg::ufiAdrsT mcsAdrs,
	input bit mcsEd,
	input bit mcsVd,
	// SPI debug, R/W
	input ufiPkg::ufiDataT spiWd,
	input ufiPkg::ufiAdrsT spiAdrs,
	input bit spiEd,
	input bit spiVd,
	input bit spiCmd,
	// ATB audio fetch, read only
	input ufiPkg::ufiAdrsT atbAdrs,
	input bit atbEd,
	input bit atbVd,
	output bit atbRdy,
	// VTB frame buffer, R/W
	input ufiPkg::ufiDataT vtbWd,
	input ufiPkg::ufiAdrsT vtbAdrs,
	input bit vtbEd,
	input bit vtbVd,
	input bit vtbCmd,
	output bit vtbRdy,
	// Shared read return
	output ufiPkg::ufiDataT masterRd,
	output bit masterRed
);

	// -----------------------------------------------------------------------
	// Slave bus
	// -----------------------------------------------------------------------
	ufiSlaveIf slaveBus ();

	// Request path plus return register
	ufiArbiter arbiter
	(
		.iUfiClk (iUfiClk),
		.rstN (rstN),
		.mcsWd (mcsWd),
		.spiWd (spiWd),
		.vtbWd (vtbWd),
		.mcsAdrs (mcsAdrs),
		.spiAdrs (spiAdrs),
		.atbAdrs (atbAdrs),
		.vtbAdrs (vtbAdrs),
		.mcsEd (mcsEd),
		.spiEd (spiEd),
		.atbEd (atbEd),
		.vtbEd (vtbEd),
		.mcsVd (mcsVd),
		.spiVd (spiVd),
		.atbVd (atbVd),
		.vtbVd (vtbVd),
		.spiCmd (spiCmd),
		.vtbCmd (vtbCmd),
		.atbRdy (atbRdy),
		.vtbRdy (vtbRdy),
		.masterRd (masterRd),
		.masterRed (masterRed),
		.slave (slaveBus.arbiter)
	);

	// Always accepts, no back-pressure
	ufiBlockRam ram
	(
		.iUfiClk (iUfiClk),
		.rstN (rstN),
		.slave (slaveBus.ram)
	);

endmodule

// File: verilog/ufiBlockRam.sv
/* Single-port block RAM slave on the slave bus
   Low address bits decoded, registered read data with valid pulse */
`timescale 1ns/1ps

`include "ufi_settings.svh"

module ufiBlockRam
(
	input bit iUfiClk,
	input bit rstN,
	ufiSlaveIf.ram slave
);

	// -----------------------------------------------------------------------
	// Storage
	// -----------------------------------------------------------------------
	localparam int ramDepth = 1 << `UFI_RAM_ADRS_BITS;		// 1024 words

	ufiPkg::ufiDataT mem [ramDepth];		// Word array

	logic [`UFI_RAM_ADRS_BITS-1:0] wordAdrs;		// Decoded word index
	bit rdStb;		// Read request this cycle
	bit wrStb;		// Write request this cycle

	// Upper address bits are ignored
	assign wordAdrs = slave.adrs[`UFI_RAM_ADRS_BITS-1:0];

	// Strobe decode
	assign rdStb = slave.ed && (slave.cmd == ufiPkg::UFI_CMD_READ);
	assign wrStb = slave.ed && (slave.cmd == ufiPkg::UFI_CMD_WRITE);

	// -----------------------------------------------------------------------
	// Write port
	// -----------------------------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (wrStb)
			mem[wordAdrs] <= slave.wd;
	end

	// -----------------------------------------------------------------------
	// Read port
	// -----------------------------------------------------------------------
	// Old contents come out, a same-edge write lands after
	always_ff @(posedge iUfiClk)
	begin
		if (rdStb)
			slave.rd <= mem[wordAdrs];
	end

	// One-cycle valid per read strobe
	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
			slave.red <= 1'b0;
		else
			slave.red <= rdStb;
	end

	// A read straight after a write to the same word sees the new data
	assert property (@(posedge iUfiClk) disable iff (!rstN)
		($past(wrStb) && rdStb && wordAdrs == $past(wordAdrs))
		|=> (slave.rd == $past(slave.wd, 2)))
		else $error("Read after write to the same word returned old data");

endmodule

// File: ufiArbiter/ufiArbiter.sv
/* Fixed-priority arbiter for four masters on one slave bus
   MCS > SPI > ATB > VTB, ATB/VTB interlock, registered read return */
`timescale 1ns/1ps

module ufiArbiter
(
	input bit iUfiClk,
	input bit rstN,
	// Write data
	input ufiPkg::ufiDataT mcsWd,
	input ufiPkg::ufiDataT spiWd,
	input ufiPkg::ufiDataT vtbWd,
	// Addresses
	input ufiPkg::ufiAdrsT mcsAdrs,
	input ufiPkg::ufiAdrsT spiAdrs,
	input ufiPkg::ufiAdrsT atbAdrs,
	input ufiPkg::ufiAdrsT vtbAdrs,
	// Enables, forwarded as the slave strobe
	input bit mcsEd,
	input bit spiEd,
	input bit atbEd,
	input bit vtbEd,
	// Valids, request qualifiers
	input bit mcsVd,
	input bit spiVd,
	input bit atbVd,
	input bit vtbVd,
	// Command bits for R/W masters
	input bit spiCmd,
	input bit vtbCmd,
	// Grant pulses
	output bit atbRdy,
	output bit vtbRdy,
	// Read return to all masters
	output ufiPkg::ufiDataT masterRd,
	output bit masterRed,
	// Slave bus
	ufiSlaveIf.arbiter slave
);

	// -----------------------------------------------------------------------
	// Grant decode
	// -----------------------------------------------------------------------
	ufiPkg::ufiGrantT grant;		// Winner for this edge

	// ATB waits out a VTB grant and vice versa
	always_comb
	begin
		if (mcsVd)
			grant = ufiPkg::GRANT_MCS;
		else if (spiVd)
			grant = ufiPkg::GRANT_SPI;
		else if (atbVd && !vtbRdy)
			grant = ufiPkg::GRANT_ATB;
		else if (vtbVd && !atbRdy)
			grant = ufiPkg::GRANT_VTB;
		else
			grant = ufiPkg::GRANT_NONE;
	end

	// -----------------------------------------------------------------------
	// Slave request, control part
	// -----------------------------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
		begin
			slave.ed <= 1'b0;
			slave.cmd <= ufiPkg::UFI_CMD_READ;		// Idle bus reads as read
			atbRdy <= 1'b0;
			vtbRdy <= 1'b0;
		end
		else
		begin
			atbRdy <= (grant == ufiPkg::GRANT_ATB);		// Pulse with bus cycle
			vtbRdy <= (grant == ufiPkg::GRANT_VTB);
			case (grant)
				ufiPkg::GRANT_MCS:
				begin
					slave.ed <= mcsEd;
					slave.cmd <= ufiPkg::UFI_CMD_WRITE;		// MCS only writes
				end
				ufiPkg::GRANT_SPI:
				begin
					slave.ed <= spiEd;
					slave.cmd <= spiCmd;		// Debug R/W
				end
				ufiPkg::GRANT_ATB:
				begin
					slave.ed <= atbEd;
					slave.cmd <= ufiPkg::UFI_CMD_READ;		// Audio fetch only reads
				end
				ufiPkg::GRANT_VTB:
				begin
					slave.ed <= vtbEd;
					slave.cmd <= vtbCmd;
				end
				default:
				begin
					slave.ed <= 1'b0;
					slave.cmd <= ufiPkg::UFI_CMD_READ;
				end
			endcase
		end
	end

	// -----------------------------------------------------------------------
	// Slave request, payload part
	// -----------------------------------------------------------------------
	always_ff @(posedge iUfiClk)
	begin
		case (grant)
			ufiPkg::GRANT_MCS:
			begin
				slave.wd <= mcsWd;
				slave.adrs <= mcsAdrs;
			end
			ufiPkg::GRANT_SPI:
			begin
				slave.wd <= spiWd;
				slave.adrs <= spiAdrs;
			end
			ufiPkg::GRANT_ATB:
			begin
				slave.wd <= '0;		// No write data on ATB
				slave.adrs <= atbAdrs;
			end
			ufiPkg::GRANT_VTB:
			begin
				slave.wd <= vtbWd;
				slave.adrs <= vtbAdrs;
			end
			default:
			begin
				slave.wd <= '0;
				slave.adrs <= '0;
			end
		endcase
	end

	// -----------------------------------------------------------------------
	// Read return, one more register stage
	// -----------------------------------------------------------------------
	always_ff @(posedge iUfiClk)
		masterRd <= slave.rd;

	always_ff @(posedge iUfiClk)
	begin
		if (!rstN)
			masterRed <= 1'b0;
		else
			masterRed <= slave.red;		// Broadcast strobe
	end

	// Interlock, no VTB grant right after an ATB grant
	assert property (@(posedge iUfiClk) disable iff (!rstN) atbRdy |=> !vtbRdy)
		else $error("VTB granted right after an ATB grant");

	// Interlock, no ATB grant right after a VTB grant
	assert property (@(posedge iUfiClk) disable iff (!rstN) vtbRdy |=> !atbRdy)
		else $error("ATB granted right after a VTB grant");

	// MCS beats every other master and reaches the slave bus as a write
	assert property (@(posedge iUfiClk) disable iff (!rstN)
		mcsVd |=> (slave.cmd == ufiPkg::UFI_CMD_WRITE && slave.adrs == $past(mcsAdrs)))
		else $error("MCS request not issued as a write on the slave bus");

endmodule

// File: common/ufiSlaveIf.sv
/* Slave bus between the arbiter and the block RAM
   Request strobe with command bit, read data with valid pulse */
`timescale 1ns/1ps

interface ufiSlaveIf;

	// Request side, arbiter to RAM
	ufiPkg::ufiDataT wd;		// Write data
	ufiPkg::ufiAdrsT adrs;		// Address for read and write
	bit ed;						// One-cycle request strobe
	bit cmd;					// High read, low write

	// Return side, RAM to arbiter
	ufiPkg::ufiDataT rd;		// Read data
	bit red;					// Read-valid pulse

	// Bus owner
	modport arbiter
	(
		output wd, adrs, ed, cmd,
		input rd, red
	);

	// Memory slave
	modport ram
	(
		input wd, adrs, ed, cmd,
		output rd, red
	);

endinterface

// File: common/ufiPkg.sv
/* Shared bus types for the memory bus subsystem
   Data word, address, grant owner and command bit encoding */
package ufiPkg;

`include "ufi_settings.svh"

	// -----------------------------------------------------------------------
	// Payload types
	// -----------------------------------------------------------------------
	typedef logic [`UFI_DATA_BITS-1:0] ufiDataT;		// One bus word
	typedef logic [`UFI_ADRS_BITS-1:0] ufiAdrsT;		// R/W address

	// -----------------------------------------------------------------------
	// Slave bus owner for one cycle
	// -----------------------------------------------------------------------
	typedef enum logic [2:0]
	{
		GRANT_NONE,		// Bus idle
		GRANT_MCS,		// Microcontroller, write only
		GRANT_SPI,		// Debug port, R/W
		GRANT_ATB,		// Audio fetch, read only
		GRANT_VTB		// Frame buffer, R/W
	} ufiGrantT;

	// -----------------------------------------------------------------------
	// Command bit
	// -----------------------------------------------------------------------
	localparam bit UFI_CMD_READ  = 1'b1;		// High is read
	localparam bit UFI_CMD_WRITE = 1'b0;		// Low is write

endpackage

// File: common/ufi_settings.svh
/* Bus widths and RAM size for the memory bus subsystem */
`ifndef UFI_SETTINGS_SVH
`define UFI_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
`define UFI_DATA_BITS 16		// Data word on the bus
`define UFI_ADRS_BITS 32		// Shared R/W address

// ---------------------------------------------------------------------------
// Block RAM
// ---------------------------------------------------------------------------
// Low address bits decoded by the RAM, 1024 words
`define UFI_RAM_ADRS_BITS 10

`endif
